//--- Makefile
TOP = issue_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	@result=$$(./obj_dir/sim_$(TOP)); \
	echo "$$result"; \
	echo "$$result" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- bench/issue_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "arm_settings.svh"

module issue_stage_tb;

	import arm_isa_pkg::*;
	import issue_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int SEED = 7481;
	localparam int MAX_WAIT = 8;
	localparam int DRAIN = `ISSUE_SB_DEPTH + 1;
	localparam int TEST_CYCLES = 2 + 8 + 14 + 15 + 20 + 30;	// Reset through classes, in run order
	localparam int MARGIN_CYCLES = 50;

	logic clk;
	logic Nrst;
	logic stall;
	logic flush;
	issue_in_t dut_in;
	psr_flags_t cpsr;
	logic out_stall;
	issue_out_t dut_out;

	int errors;
	int tests_run;
	int failed_tests;
	logic seen_stall;
	reg_idx_t rr [8];	// Distinct registers below R14 for the current test

	issue_stage uut (
		.clk(clk),
		.Nrst(Nrst),
		.stall(stall),
		.flush(flush),
		.in(dut_in),
		.cpsr(cpsr),
		.out_stall(out_stall),
		.out(dut_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Register operand shifted LSL #1, so the carry flag is not read
	function automatic arm_word_t dp_reg(input cond_code_t cond, input alu_op_t op,
		input logic s, input reg_idx_t rn, input reg_idx_t rd, input reg_idx_t rm);
		return {cond, 3'b000, op, s, rn, rd, 5'd1, SHIFT_LSL, 1'b0, rm};
	endfunction

	function automatic arm_word_t dp_imm(input cond_code_t cond, input alu_op_t op,
		input reg_idx_t rd, input logic [7:0] imm);
		return {cond, 3'b001, op, 1'b0, 4'd0, rd, 4'd0, imm};
	endfunction

	task automatic report_value(input string name, input arm_word_t got, input arm_word_t exp);
		$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	// out_stall is sampled before the rising edge, out just after it
	task automatic drive_slot(input logic bub, input arm_word_t insn, input arm_word_t pc,
		input logic hold, input logic kill);
		@(negedge clk);
		dut_in = '{bubble: bub, insn: insn, pc: pc};
		stall = hold;
		flush = kill;
		#1 seen_stall = out_stall;
		@(posedge clk);
		#1;
	endtask

	task automatic check_out(input logic bub, input arm_word_t insn, input arm_word_t pc);
		if (dut_out.bubble !== bub)
			report_value("out.bubble", 32'(dut_out.bubble), 32'(bub));
		if (dut_out.insn !== insn)
			report_value("out.insn", dut_out.insn, insn);
		if (dut_out.pc !== pc)
			report_value("out.pc", dut_out.pc, pc);
	endtask

	task automatic issue_free(input arm_word_t insn, input arm_word_t pc);
		drive_slot(1'b0, insn, pc, 1'b0, 1'b0);
		if (seen_stall !== 1'b0)
			report_value("out_stall", 32'(seen_stall), 32'd0);
		check_out(1'b0, insn, pc);
	endtask

	// Keeps the instruction at the input until the stage lets it go
	task automatic issue_waiting(input arm_word_t insn, input arm_word_t pc,
		input logic bub, input int exp_stalls);
		int cycles;
		logic hold;
		cycles = 0;
		seen_stall = 1'b1;
		while (seen_stall === 1'b1 && cycles <= MAX_WAIT)
		begin
			drive_slot(1'b0, insn, pc, 1'b0, 1'b0);
			hold = (cycles < exp_stalls);
			if (seen_stall !== hold)
				report_value("out_stall", 32'(seen_stall), 32'(hold));
			check_out(hold | bub, insn, pc);	// Every held cycle goes out as a bubble
			cycles++;
		end
		if (seen_stall === 1'b1)
		begin
			$display("Failure at %0t: instruction %h still stalled after %0d cycles",
				$time, insn, cycles);
			errors++;
		end
	endtask

	task automatic drain_pipe();
		repeat (DRAIN) drive_slot(1'b1, '0, '0, 1'b0, 1'b0);
	endtask

	task automatic pick_regs();
		int n;
		reg_idx_t cand;
		logic fresh;
		n = 0;
		while (n < 8)
		begin
			cand = reg_idx_t'($urandom % `ARM_LR_REG);
			fresh = 1'b1;
			for (int i = 0; i < n; i++)
				if (rr[i] == cand)
					fresh = 1'b0;
			if (fresh)
			begin
				rr[n] = cand;
				n++;
			end
		end
	endtask

	task automatic finish_test(input string name, input int start);
		tests_run++;
		if (errors == start)
			$display("%s: ok", name);
		else
		begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - start);
		end
	endtask

	task automatic reset_state();
		int start;
		start = errors;
		// Values held by the reset itself, before any clock edge
		if (dut_out.bubble !== 1'b1)
			report_value("out.bubble", 32'(dut_out.bubble), 32'd1);
		if (out_stall !== 1'b0)
			report_value("out_stall", 32'(out_stall), 32'd0);
		drive_slot(1'b1, '0, '0, 1'b0, 1'b0);
		if (dut_out.bubble !== 1'b1)
			report_value("out.bubble", 32'(dut_out.bubble), 32'd1);
		if (seen_stall !== 1'b0)
			report_value("out_stall", 32'(seen_stall), 32'd0);
		finish_test("reset", start);
	endtask

	task automatic independent_stream();
		int start;
		start = errors;
		pick_regs();
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[3], rr[0], rr[4]), 32'h100);
		issue_free(dp_reg(COND_AL, ALU_SUB, 1'b0, rr[4], rr[1], rr[3]), 32'h104);
		issue_free(dp_reg(COND_AL, ALU_ORR, 1'b0, rr[3], rr[2], rr[4]), 32'h108);
		drain_pipe();
		finish_test("independent instructions", start);
	endtask

	task automatic register_hazard();
		int start;
		start = errors;
		pick_regs();
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[1], rr[0], rr[2]), 32'h200);
		issue_waiting(dp_reg(COND_AL, ALU_SUB, 1'b0, rr[0], rr[3], rr[4]), 32'h204, 1'b0, 2);
		drain_pipe();
		// A write to the PC is not tracked, so reading it never waits
		issue_free(dp_imm(COND_AL, ALU_MOV, reg_idx_t'(`ARM_PC_REG), 8'h40), 32'h210);
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, reg_idx_t'(`ARM_PC_REG), rr[5],
			reg_idx_t'(`ARM_PC_REG)), 32'h214);
		drain_pipe();
		finish_test("register hazard", start);
	endtask

	task automatic flag_hazard();
		int start;
		arm_word_t adds;
		start = errors;
		pick_regs();
		adds = dp_reg(COND_AL, ALU_ADD, 1'b1, rr[1], rr[0], rr[2]);
		cpsr = '0;	// Z clear, so EQ fails
		issue_free(adds, 32'h300);
		issue_waiting(dp_imm(COND_EQ, ALU_MOV, rr[3], 8'h05), 32'h304, 1'b1, 2);
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[3], rr[4], rr[3]), 32'h308);
		drain_pipe();
		issue_free(adds, 32'h310);
		issue_free(dp_imm(COND_AL, ALU_MOV, rr[5], 8'h07), 32'h314);
		drain_pipe();
		finish_test("flag hazard and conditions", start);
	endtask

	task automatic stall_and_flush();
		int start;
		arm_word_t a;
		arm_word_t b;
		arm_word_t q;
		start = errors;
		pick_regs();
		a = dp_reg(COND_AL, ALU_ADD, 1'b0, rr[1], rr[0], rr[2]);
		b = dp_reg(COND_AL, ALU_ADD, 1'b0, rr[0], rr[3], rr[2]);
		q = dp_reg(COND_AL, ALU_SUB, 1'b0, rr[4], rr[5], rr[2]);
		issue_free(a, 32'h400);
		// The producer of b stays in execute while downstream is stalled
		repeat (3)
		begin
			drive_slot(1'b0, b, 32'h404, 1'b1, 1'b0);
			if (seen_stall !== 1'b1)
				report_value("out_stall", 32'(seen_stall), 32'd1);
			check_out(1'b0, a, 32'h400);
		end
		issue_waiting(b, 32'h404, 1'b0, 2);
		drive_slot(1'b0, a, 32'h408, 1'b0, 1'b1);
		check_out(1'b1, a, 32'h408);
		drain_pipe();
		// Flush arrives while q is held on its producer and downstream is stalled
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[1], rr[4], rr[2]), 32'h410);
		drive_slot(1'b0, q, 32'h414, 1'b0, 1'b0);
		if (seen_stall !== 1'b1)
			report_value("out_stall", 32'(seen_stall), 32'd1);
		check_out(1'b1, q, 32'h414);
		drive_slot(1'b0, q, 32'h414, 1'b1, 1'b1);
		if (seen_stall !== 1'b1)
			report_value("out_stall", 32'(seen_stall), 32'd1);
		check_out(1'b1, q, 32'h414);
		issue_waiting(q, 32'h414, 1'b1, 1);
		issue_free(b, 32'h418);
		drain_pipe();
		finish_test("back-pressure and flush", start);
	endtask

	task automatic insn_classes();
		int start;
		reg_mask_t list;
		arm_word_t ldm;
		arm_word_t bl;
		start = errors;
		pick_regs();
		list = (reg_mask_t'(1) << rr[1]) | (reg_mask_t'(1) << rr[2]);
		ldm = {COND_AL, 3'b100, 5'b01011, rr[0], list};	// LDMIA with writeback
		bl = {COND_AL, 4'b1011, 24'h000010};
		issue_free(ldm, 32'h500);
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[4], rr[3], rr[5]), 32'h504);
		issue_waiting(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[1], rr[6], rr[4]), 32'h508, 1'b0, 1);
		drain_pipe();
		issue_free(ldm, 32'h510);
		issue_waiting(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[0], rr[7], rr[4]), 32'h514, 1'b0, 2);
		drain_pipe();
		issue_free(bl, 32'h520);
		issue_waiting(dp_reg(COND_AL, ALU_ADD, 1'b0, reg_idx_t'(`ARM_LR_REG), rr[3], rr[4]),
			32'h524, 1'b0, 2);
		drain_pipe();
		issue_free(bl, 32'h530);
		issue_free(dp_reg(COND_AL, ALU_ADD, 1'b0, rr[4], rr[3], rr[5]), 32'h534);
		drain_pipe();
		finish_test("instruction classes", start);
	endtask

	initial
	begin
		errors = 0;
		tests_run = 0;
		failed_tests = 0;
		seen_stall = 1'b0;
		void'($urandom(SEED));
		Nrst = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		dut_in = '{bubble: 1'b1, insn: '0, pc: '0};
		cpsr = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		Nrst = 1'b1;
		reset_state();
		independent_stream();
		register_hazard();
		flag_hazard();
		stall_and_flush();
		insn_classes();
		$display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
		if (errors == 0 && failed_tests == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Ends a run that hangs on a test
	initial
	begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles",
			RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/arm_isa_pkg.sv
logic/issue_pkg.sv
logic/insn_classifier.sv
logic/cond_check.sv
logic/hazard_scoreboard.sv
logic/issue_stage.sv
bench/issue_stage_tb.sv

//--- include/arm_settings.svh
`ifndef ARM_SETTINGS_SVH
`define ARM_SETTINGS_SVH

// Architectural register file shape
`define ARM_NUM_REGS 16

// The program counter is never tracked as a hazard
`define ARM_PC_REG 15

// Link register, written by branch-with-link
`define ARM_LR_REG 14

// Width of an instruction word, a PC and the status register
`define ARM_WORD_BITS 32

// In-flight stages that can still owe a result: execute and memory
// Once an instruction reaches writeback its result is in the register file
`define ISSUE_SB_DEPTH 2

`endif

//--- logic/arm_isa_pkg.sv
`default_nettype none

`include "arm_settings.svh"

package arm_isa_pkg;

	typedef logic [`ARM_WORD_BITS-1:0] arm_word_t;		// Instruction or PC word
	typedef logic [$clog2(`ARM_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [`ARM_NUM_REGS-1:0] reg_mask_t;		// One bit per general register

	// Condition field, insn[31:28]
	typedef enum logic [3:0] {
		COND_EQ = 4'h0,
		COND_NE = 4'h1,
		COND_CS = 4'h2,
		COND_CC = 4'h3,
		COND_MI = 4'h4,
		COND_PL = 4'h5,
		COND_VS = 4'h6,
		COND_VC = 4'h7,
		COND_HI = 4'h8,
		COND_LS = 4'h9,
		COND_GE = 4'hA,
		COND_LT = 4'hB,
		COND_GT = 4'hC,
		COND_LE = 4'hD,
		COND_AL = 4'hE,
		COND_NV = 4'hF
	} cond_code_t;

	// Data-processing opcode, insn[24:21]
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'hA,
		ALU_CMN = 4'hB,
		ALU_ORR = 4'hC,
		ALU_MOV = 4'hD,
		ALU_BIC = 4'hE,
		ALU_MVN = 4'hF
	} alu_op_t;

	// Barrel shifter operation, insn[6:5]
	typedef enum logic [1:0] {
		SHIFT_LSL = 2'd0,
		SHIFT_LSR = 2'd1,
		SHIFT_ASR = 2'd2,
		SHIFT_ROR = 2'd3
	} shift_kind_t;

	// Same bit layout as the CPSR, flags in the top nibble
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
		logic [`ARM_WORD_BITS-5:0] other;	// Mode, interrupt masks and reserved bits
	} psr_flags_t;

endpackage

`default_nettype wire

//--- logic/cond_check.sv
`timescale 1ns/10ps
`default_nettype none

module cond_check (
	input wire arm_isa_pkg::cond_code_t cond,
	input wire arm_isa_pkg::psr_flags_t flags,
	output logic cond_met
);

	import arm_isa_pkg::*;

	always_comb
	begin
		case (cond)
			COND_EQ: cond_met = flags.z;
			COND_NE: cond_met = ~flags.z;
			COND_CS: cond_met = flags.c;
			COND_CC: cond_met = ~flags.c;
			COND_MI: cond_met = flags.n;
			COND_PL: cond_met = ~flags.n;
			COND_VS: cond_met = flags.v;
			COND_VC: cond_met = ~flags.v;
			COND_HI: cond_met = flags.c & ~flags.z;		// Unsigned higher
			COND_LS: cond_met = ~flags.c | flags.z;
			COND_GE: cond_met = (flags.n == flags.v);	// Signed compares
			COND_LT: cond_met = (flags.n != flags.v);
			COND_GT: cond_met = ~flags.z & (flags.n == flags.v);
			COND_LE: cond_met = flags.z | (flags.n != flags.v);
			COND_AL: cond_met = 1'b1;
			COND_NV: cond_met = 1'b0;
			default: cond_met = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/hazard_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

`include "arm_settings.svh"

module hazard_scoreboard (
	input wire clk,
	input wire Nrst,
	input wire advance,
	input wire record,
	input wire issue_pkg::reg_usage_t usage,
	output logic waiting_cpsr,
	output logic waiting_regs
);

	import arm_isa_pkg::*;

	localparam int DEPTH = `ISSUE_SB_DEPTH;

	// Slot 0 is execute, the last slot is memory
	logic sb_cpsr [DEPTH];
	reg_mask_t sb_regs [DEPTH];
	logic pending_cpsr;
	reg_mask_t pending_regs;

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				sb_cpsr[i] <= 1'b0;
				sb_regs[i] <= '0;
			end
		end
		else if (advance)
		begin
			for (int i = DEPTH - 1; i > 0; i--)
			begin
				sb_cpsr[i] <= sb_cpsr[i-1];
				sb_regs[i] <= sb_regs[i-1];
			end
			sb_cpsr[0] <= record ? usage.def_cpsr : 1'b0;	// An unissued slot owes nothing
			sb_regs[0] <= record ? usage.def_regs : '0;
		end
	end

	// Anything still owed by execute or memory
	always_comb
	begin
		pending_cpsr = 1'b0;
		pending_regs = '0;
		for (int i = 0; i < DEPTH; i++)
		begin
			pending_cpsr = pending_cpsr | sb_cpsr[i];
			pending_regs = pending_regs | sb_regs[i];
		end
	end

	assign waiting_cpsr = usage.use_cpsr & pending_cpsr;
	assign waiting_regs = |(usage.use_regs & pending_regs);

endmodule

`default_nettype wire

//--- logic/insn_classifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "arm_settings.svh"

module insn_classifier (
	input wire arm_isa_pkg::arm_word_t insn,
	output issue_pkg::reg_usage_t usage
);

	import arm_isa_pkg::*;

	// Instruction classes, matched in this order since several overlap the ALU space
	localparam arm_word_t DEC_MULT      = 32'b????_0000_00??_????_????_????_1001_????;
	localparam arm_word_t DEC_MRS       = 32'b????_0001_0?00_1111_????_0000_0000_0000;
	localparam arm_word_t DEC_MSR       = 32'b????_0001_0?10_1001_1111_0000_0000_????;
	localparam arm_word_t DEC_MSR_FLAGS = 32'b????_00?1_0?10_1000_1111_????_????_????;
	localparam arm_word_t DEC_SWP       = 32'b????_0001_0?00_????_????_0000_1001_????;
	localparam arm_word_t DEC_BX        = 32'b????_0001_0010_1111_1111_1111_0001_????;
	localparam arm_word_t DEC_HDATA_REG = 32'b????_000?_?0??_????_????_0000_1??1_????;
	localparam arm_word_t DEC_HDATA_IMM = 32'b????_000?_?1??_????_????_????_1??1_????;
	localparam arm_word_t DEC_ALU       = 32'b????_00??_????_????_????_????_????_????;
	localparam arm_word_t DEC_UNDEF     = 32'b????_011?_????_????_????_????_???1_????;
	localparam arm_word_t DEC_LDRSTR    = 32'b????_01??_????_????_????_????_????_????;
	localparam arm_word_t DEC_LDMSTM    = 32'b????_100?_????_????_????_????_????_????;
	localparam arm_word_t DEC_BRANCH    = 32'b????_101?_????_????_????_????_????_????;
	localparam arm_word_t DEC_LDCSTC    = 32'b????_110?_????_????_????_????_????_????;
	localparam arm_word_t DEC_CDP       = 32'b????_1110_????_????_????_????_???0_????;
	localparam arm_word_t DEC_MRCMCR    = 32'b????_1110_????_????_????_????_???1_????;
	localparam arm_word_t DEC_SWI       = 32'b????_1111_????_????_????_????_????_????;

	localparam reg_mask_t PC_MASK = reg_mask_t'(1) << `ARM_PC_REG;

	reg_idx_t rn;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rm;
	reg_idx_t rd_mul;
	reg_idx_t rn_mul;
	cond_code_t cond;
	alu_op_t alu_op;
	shift_kind_t shift_kind;
	reg_mask_t reg_list;
	logic cond_used;
	logic shift_uses_carry;
	logic base_wb;

	// R15 is dropped from every mask here
	function automatic reg_mask_t reg_bit(input reg_idx_t r);
		return (reg_mask_t'(1) << r) & ~PC_MASK;
	endfunction

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign rd_mul = insn[19:16];	// Multiply swaps the Rd and Rn fields
	assign rn_mul = insn[15:12];
	assign cond = cond_code_t'(insn[31:28]);
	assign alu_op = alu_op_t'(insn[24:21]);
	assign shift_kind = shift_kind_t'(insn[6:5]);
	assign reg_list = reg_mask_t'(insn[`ARM_NUM_REGS-1:0]) & ~PC_MASK;
	assign cond_used = (cond != COND_AL);

	// Immediate LSL #0 passes the carry through, ROR #0 is RRX
	assign shift_uses_carry = ~insn[4] && (insn[11:7] == 5'd0) &&
		(shift_kind == SHIFT_LSL || shift_kind == SHIFT_ROR);

	// Post-indexed transfers always write the base back
	assign base_wb = insn[21] | ~insn[24];

	always_comb
	begin
		usage = '0;
		usage.use_cpsr = cond_used;	// Most classes read the flags only for the condition
		casez (insn)
			DEC_MULT:
			begin
				usage.use_regs = reg_bit(rs) | reg_bit(rm) | (insn[21] ? reg_bit(rn_mul) : '0);
				usage.def_cpsr = insn[20];
				usage.def_regs = reg_bit(rd_mul);
			end
			DEC_MRS:
			begin
				usage.use_cpsr = cond_used | ~insn[22];	// Source is the CPSR rather than the SPSR
				usage.def_regs = reg_bit(rd);
			end
			DEC_MSR:
			begin
				usage.use_regs = reg_bit(rm);
				usage.def_cpsr = 1'b1;
			end
			DEC_MSR_FLAGS:
			begin
				usage.use_regs = insn[25] ? '0 : reg_bit(rm);
				usage.def_cpsr = 1'b1;
			end
			DEC_SWP:
			begin
				usage.use_regs = reg_bit(rn) | reg_bit(rm);
				usage.def_regs = reg_bit(rd);
			end
			DEC_BX:
				usage.use_regs = reg_bit(rm);
			DEC_HDATA_REG:
			begin
				usage.use_regs = reg_bit(rn) | reg_bit(rm) | (insn[20] ? '0 : reg_bit(rd));
				usage.def_regs = (insn[20] ? reg_bit(rd) : '0) | (base_wb ? reg_bit(rn) : '0);
			end
			DEC_HDATA_IMM:
			begin
				usage.use_regs = reg_bit(rn) | (insn[20] ? '0 : reg_bit(rd));
				usage.def_regs = (insn[20] ? reg_bit(rd) : '0) | (base_wb ? reg_bit(rn) : '0);
			end
			DEC_ALU:
			begin
				// The carry-in opcodes always consume C
				usage.use_cpsr = cond_used | (~insn[25] & shift_uses_carry) |
					(alu_op inside {ALU_ADC, ALU_SBC, ALU_RSC});
				if (~insn[25])
					usage.use_regs = reg_bit(rm) | (insn[4] ? reg_bit(rs) : '0);
				if (alu_op != ALU_MOV && alu_op != ALU_MVN)
					usage.use_regs |= reg_bit(rn);
				usage.def_cpsr = insn[20];
				if (!(alu_op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN}))
					usage.def_regs = reg_bit(rd);
			end
			DEC_UNDEF:
				usage.use_cpsr = 1'b0;	// Traps, nothing to wait for
			DEC_LDRSTR:
			begin
				// Here bit 25 set means a register offset
				usage.use_regs = reg_bit(rn) | (insn[25] ? reg_bit(rm) : '0) |
					(insn[20] ? '0 : reg_bit(rd));
				usage.def_regs = (insn[20] ? reg_bit(rd) : '0) | (base_wb ? reg_bit(rn) : '0);
			end
			DEC_LDMSTM:
			begin
				usage.use_regs = reg_bit(rn) | (insn[20] ? '0 : reg_list);
				// Load with S and R15 in the list restores the CPSR
				usage.def_cpsr = insn[22] & insn[20] & insn[`ARM_PC_REG];
				usage.def_regs = (insn[21] ? reg_bit(rn) : '0) | (insn[20] ? reg_list : '0);
			end
			DEC_BRANCH:
				usage.def_regs = insn[24] ? reg_bit(reg_idx_t'(`ARM_LR_REG)) : '0;
			DEC_LDCSTC:
			begin
				usage.use_regs = reg_bit(rn);
				usage.def_regs = insn[21] ? reg_bit(rn) : '0;
			end
			DEC_CDP:
				usage.use_regs = '0;	// Works only on coprocessor registers
			DEC_MRCMCR:
			begin
				usage.use_regs = insn[20] ? '0 : reg_bit(rd);
				usage.def_regs = insn[20] ? reg_bit(rd) : '0;
			end
			DEC_SWI:
				usage.def_regs = '0;
			default:
				usage = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

	import arm_isa_pkg::*;

	// What the decode stage presents each cycle
	typedef struct packed {
		logic bubble;		// Slot carries no instruction
		arm_word_t insn;
		arm_word_t pc;
	} issue_in_t;

	// What execute receives, registered
	typedef struct packed {
		logic bubble;
		arm_word_t insn;
		arm_word_t pc;
	} issue_out_t;

	// Resources one instruction reads and writes
	typedef struct packed {
		logic use_cpsr;
		reg_mask_t use_regs;
		logic def_cpsr;
		reg_mask_t def_regs;
	} reg_usage_t;

endpackage

`default_nettype wire

//--- logic/issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
	input wire clk,
	input wire Nrst,
	input wire stall,			// Downstream is not taking anything
	input wire flush,
	input wire issue_pkg::issue_in_t in,
	input wire arm_isa_pkg::psr_flags_t cpsr,
	output logic out_stall,		// Freezes the decode stage
	output issue_pkg::issue_out_t out
);

	import arm_isa_pkg::*;
	import issue_pkg::*;

	reg_usage_t usage;
	cond_code_t insn_cond;
	logic cond_met;
	logic waiting_cpsr;
	logic waiting_regs;
	logic waiting;
	logic issue_ok;
	logic delayed_flush;
	logic out_bubble;
	arm_word_t out_insn;
	arm_word_t out_pc;

	assign insn_cond = cond_code_t'(in.insn[31:28]);

	insn_classifier u_classifier (
		.insn(in.insn),
		.usage(usage)
	);

	cond_check u_cond_check (
		.cond(insn_cond),
		.flags(cpsr),
		.cond_met(cond_met)
	);

	// In-flight results move on whenever downstream moves
	hazard_scoreboard u_scoreboard (
		.clk(clk),
		.Nrst(Nrst),
		.advance(~stall),
		.record(issue_ok),
		.usage(usage),
		.waiting_cpsr(waiting_cpsr),
		.waiting_regs(waiting_regs)
	);

	assign waiting = waiting_cpsr | waiting_regs;

	// A flushed instruction is thrown away, so it has nothing to wait for
	assign out_stall = stall | (waiting & ~in.bubble & ~flush);

	// A failed condition goes down the pipe as a bubble and owes no result
	assign issue_ok = ~in.bubble & ~waiting & cond_met;

	// Remembers a flush that could not be applied while the stage was held
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			delayed_flush <= 1'b0;
		else if (flush && out_stall)
			delayed_flush <= 1'b1;
		else if (!out_stall)
			delayed_flush <= 1'b0;	// Consumed by this issue
	end

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			out_bubble <= 1'b1;
		else if (!stall)
			out_bubble <= ~issue_ok | flush | delayed_flush;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			out_insn <= in.insn;
			out_pc <= in.pc;
		end
	end

	assign out = '{bubble: out_bubble, insn: out_insn, pc: out_pc};

endmodule

`default_nettype wire
